/* Bender.yml */
package:
  name: dual_decode_stage

sources:
  - include_dirs:
      - source
    files:
      - source/rvIsaPkg.sv
      - source/pipeCtrlPkg.sv
      - source/stageIfs.sv
      - source/immGen.sv
      - source/instrDecoder.sv
      - source/regFile.sv
      - source/dualDecodeStage.sv
  - target: test
    files:
      - verification/dualDecodeStage_props.sv
      - verification/dualDecodeStageTb.sv

/* dualDecodeStage.f */
+incdir+source
source/rvIsaPkg.sv
source/pipeCtrlPkg.sv
source/stageIfs.sv
source/immGen.sv
source/instrDecoder.sv
source/regFile.sv
source/dualDecodeStage.sv
verification/dualDecodeStage_props.sv
verification/dualDecodeStageTb.sv

/* source/dualDecodeStage.sv */
`timescale 1ns/1ps

module dualDecodeStage
    import rvIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      decodeEnable,
    input  instrT     instr1,
    input  instrT     instr2,
    // lane 1 decode
    output logic      regWrite1,
    output resultSrcE resultSrc1,
    output memSizeT   memSize1,
    output aluOpE     aluControl1,
    output logic      aluSrc1,
    output xlenDataT  imm1,
    output regAddrT   rs1Addr1,
    output regAddrT   rs2Addr1,
    output regAddrT   rdAddr1,
    output logic      jump1,
    output logic      branch1,
    output logic      ecall1,
    // lane 2 decode
    output logic      regWrite2,
    output resultSrcE resultSrc2,
    output memSizeT   memSize2,
    output aluOpE     aluControl2,
    output logic      aluSrc2,
    output xlenDataT  imm2,
    output regAddrT   rs1Addr2,
    output regAddrT   rs2Addr2,
    output regAddrT   rdAddr2,
    output logic      jump2,
    output logic      branch2,
    output logic      ecall2,
    // register reads
    output xlenDataT  readData1Lane1,
    output xlenDataT  readData2Lane1,
    output xlenDataT  readData1Lane2,
    output xlenDataT  readData2Lane2,
    // writeback
    input  logic      wbEnable,
    input  regAddrT   wbRd1,
    input  regAddrT   wbRd2,
    input  logic      wbRegWrite1,
    input  logic      wbRegWrite2,
    input  xlenDataT  wbResult1,
    input  xlenDataT  wbResult2
);

    decodeCtrlIf ctrl1 ();
    decodeCtrlIf ctrl2 ();
    regReadIf    rdPort1 ();
    regReadIf    rdPort2 ();

    instrDecoder i_decode1 (.instr(instr1), .decodeEnable(decodeEnable), .ctrl(ctrl1));
    instrDecoder i_decode2 (.instr(instr2), .decodeEnable(decodeEnable), .ctrl(ctrl2));

    // raw fields, not the decoded rs, so reads happen for every format
    assign rdPort1.addr1 = instr1[19:15];
    assign rdPort1.addr2 = instr1[24:20];
    assign rdPort2.addr1 = instr2[19:15];
    assign rdPort2.addr2 = instr2[24:20];

    regFile i_regFile (
        .clk      (clk),
        .rstN     (rstN),
        .wbEnable (wbEnable),
        .wrAddr1  (wbRd1),
        .wrAddr2  (wbRd2),
        .wrEn1    (wbRegWrite1),
        .wrEn2    (wbRegWrite2),
        .wrData1  (wbResult1),
        .wrData2  (wbResult2),
        .rd1      (rdPort1),
        .rd2      (rdPort2)
    );

    assign readData1Lane1 = rdPort1.data1;
    assign readData2Lane1 = rdPort1.data2;
    assign readData1Lane2 = rdPort2.data1;
    assign readData2Lane2 = rdPort2.data2;

    assign regWrite1   = ctrl1.regWrite;
    assign resultSrc1  = ctrl1.resultSrc;
    assign memSize1    = ctrl1.memSize;
    assign aluControl1 = ctrl1.aluControl;
    assign aluSrc1     = ctrl1.aluSrc;
    assign imm1        = ctrl1.imm;
    assign rs1Addr1    = ctrl1.rs1;
    assign rs2Addr1    = ctrl1.rs2;
    assign rdAddr1     = ctrl1.rd;
    assign jump1       = ctrl1.jump;
    assign branch1     = ctrl1.branch;
    assign ecall1      = ctrl1.ecall;

    assign regWrite2   = ctrl2.regWrite;
    assign resultSrc2  = ctrl2.resultSrc;
    assign memSize2    = ctrl2.memSize;
    assign aluControl2 = ctrl2.aluControl;
    assign aluSrc2     = ctrl2.aluSrc;
    assign imm2        = ctrl2.imm;
    assign rs1Addr2    = ctrl2.rs1;
    assign rs2Addr2    = ctrl2.rs2;
    assign rdAddr2     = ctrl2.rd;
    assign jump2       = ctrl2.jump;
    assign branch2     = ctrl2.branch;
    assign ecall2      = ctrl2.ecall;

endmodule

/* source/immGen.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module immGen
    import rvIsaPkg::*, pipeCtrlPkg::*;
(
    input  instrT    instr,
    input  immFmtE   fmt,
    output xlenDataT imm
);

    logic sign;

    assign sign = instr[31];    // every format sign-extends from bit 31

    always_comb begin
        case (fmt)
            I: imm = {{(`XLEN-12){sign}}, instr[31:20]};
            S: imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            B: imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            U: imm = {{(`XLEN-32){sign}}, instr[31:12], 12'b0};
            J: imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;  // NONE
        endcase
    end

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
    import rvIsaPkg::*, pipeCtrlPkg::*;
(
    input  instrT           instr,
    input  logic            decodeEnable,
    decodeCtrlIf.dec        ctrl
);

    immFmtE     fmt;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    immGen i_immGen (
        .instr (instr),
        .fmt   (fmt),
        .imm   (ctrl.imm)   // fmt stays NONE while disabled
    );

    always_comb begin
        fmt             = NONE;
        ctrl.regWrite   = 1'b0;
        ctrl.resultSrc  = ALU;
        ctrl.memSize    = '0;
        ctrl.aluControl = NOP;
        ctrl.aluSrc     = 1'b0;
        ctrl.rs1        = '0;
        ctrl.rs2        = '0;
        ctrl.rd         = '0;
        ctrl.jump       = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.ecall      = 1'b0;

        if (decodeEnable) begin
            case (opcodeE'(instr[6:0]))
                LOAD: begin
                    fmt             = I;
                    ctrl.regWrite   = 1'b1;
                    ctrl.resultSrc  = MEM;
                    ctrl.memSize    = {2'b01, funct3};
                    ctrl.aluSrc     = 1'b1;
                    ctrl.rs1        = instr[19:15];
                    ctrl.rd         = instr[11:7];
                    ctrl.aluControl = ADD;  // address calc
                end
                OP_IMM, OP_IMM_32: begin
                    fmt           = I;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.rs1      = instr[19:15];
                    ctrl.rd       = instr[11:7];
                    if (instr[6:0] == OP_IMM) begin
                        case (funct3)
                            3'b000: ctrl.aluControl = ADD;
                            3'b001: ctrl.aluControl = SLL;
                            3'b010: ctrl.aluControl = SLT;
                            3'b011: ctrl.aluControl = SLTU;
                            3'b100: ctrl.aluControl = XOR_OP;
                            3'b101: begin
                                // shamt is 6 bits on RV64, so funct6
                                if (instr[31:26] == 6'b000000) ctrl.aluControl = SRL;
                                if (instr[31:26] == 6'b010000) ctrl.aluControl = SRA;
                            end
                            3'b110: ctrl.aluControl = OR_OP;
                            default: ctrl.aluControl = AND_OP;
                        endcase
                    end else begin
                        case (funct3)
                            3'b000: ctrl.aluControl = ADDW;
                            3'b001: ctrl.aluControl = SLLW;
                            3'b101: begin
                                if (funct7 == 7'b0000000) ctrl.aluControl = SRLW;
                                if (funct7 == 7'b0100000) ctrl.aluControl = SRAW;
                            end
                            default: ctrl.aluControl = NOP;
                        endcase
                    end
                end
                rvIsaPkg::AUIPC, rvIsaPkg::LUI: begin
                    fmt           = U;
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.rd       = instr[11:7];
                    ctrl.aluControl = (instr[6:0] == rvIsaPkg::LUI) ?
                                      pipeCtrlPkg::LUI : pipeCtrlPkg::AUIPC;
                end
                STORE: begin
                    fmt             = S;
                    ctrl.memSize    = {2'b10, funct3};
                    ctrl.aluSrc     = 1'b1;
                    ctrl.rs1        = instr[19:15];
                    ctrl.rs2        = instr[24:20];
                    ctrl.rd         = instr[11:7];  // imm bits, as in the core
                    ctrl.aluControl = ADD;
                end
                OP: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.rs1      = instr[19:15];
                    ctrl.rs2      = instr[24:20];
                    ctrl.rd       = instr[11:7];
                    case ({funct7, funct3})
                        {7'b0000000, 3'b000}: ctrl.aluControl = ADD;
                        {7'b0100000, 3'b000}: ctrl.aluControl = SUB;
                        {7'b0000000, 3'b001}: ctrl.aluControl = SLL;
                        {7'b0000000, 3'b010}: ctrl.aluControl = SLT;
                        {7'b0000000, 3'b011}: ctrl.aluControl = SLTU;
                        {7'b0000000, 3'b100}: ctrl.aluControl = XOR_OP;
                        {7'b0000000, 3'b101}: ctrl.aluControl = SRL;
                        {7'b0100000, 3'b101}: ctrl.aluControl = SRA;
                        {7'b0000000, 3'b110}: ctrl.aluControl = OR_OP;
                        {7'b0000000, 3'b111}: ctrl.aluControl = AND_OP;
                        {7'b0000001, 3'b000}: ctrl.aluControl = MUL;    // M extension
                        {7'b0000001, 3'b001}: ctrl.aluControl = MULH;
                        {7'b0000001, 3'b010}: ctrl.aluControl = MULHSU;
                        {7'b0000001, 3'b011}: ctrl.aluControl = MULHU;
                        {7'b0000001, 3'b100}: ctrl.aluControl = DIV;
                        {7'b0000001, 3'b101}: ctrl.aluControl = DIVU;
                        {7'b0000001, 3'b110}: ctrl.aluControl = REM;
                        {7'b0000001, 3'b111}: ctrl.aluControl = REMU;
                        default:              ctrl.aluControl = NOP;
                    endcase
                end
                OP_32: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.rs1      = instr[19:15];
                    ctrl.rs2      = instr[24:20];
                    ctrl.rd       = instr[11:7];
                    case (funct3)
                        3'b000: begin
                            if (funct7 == 7'b0000000) ctrl.aluControl = ADDW;
                            if (funct7 == 7'b0000001) ctrl.aluControl = MULW;
                            if (funct7 == 7'b0100000) ctrl.aluControl = SUBW;
                        end
                        3'b001: ctrl.aluControl = SLLW;
                        3'b100: ctrl.aluControl = DIVW;
                        3'b101: begin
                            if (funct7 == 7'b0000000) ctrl.aluControl = SRLW;
                            if (funct7 == 7'b0000001) ctrl.aluControl = DIVUW;
                            if (funct7 == 7'b0100000) ctrl.aluControl = SRAW;
                        end
                        3'b110: ctrl.aluControl = REMW;
                        3'b111: ctrl.aluControl = REMUW;
                        default: ctrl.aluControl = NOP;
                    endcase
                end
                BRANCH: begin
                    fmt         = B;
                    ctrl.branch = 1'b1;
                    ctrl.rs1    = instr[19:15];
                    ctrl.rs2    = instr[24:20];
                    case (funct3)
                        3'b000: ctrl.aluControl = BEQ;
                        3'b001: ctrl.aluControl = BNE;
                        3'b100: ctrl.aluControl = BLT;
                        3'b101: ctrl.aluControl = BGE;
                        3'b110: ctrl.aluControl = BLTU;
                        3'b111: ctrl.aluControl = BGEU;
                        default: ctrl.aluControl = NOP;
                    endcase
                end
                rvIsaPkg::JALR, rvIsaPkg::JAL: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSrc = PC4;
                    ctrl.jump      = 1'b1;
                    ctrl.aluSrc    = 1'b1;
                    ctrl.rd        = instr[11:7];
                    if (instr[6:0] == rvIsaPkg::JALR) begin
                        fmt             = I;
                        ctrl.rs1        = instr[19:15];
                        ctrl.aluControl = pipeCtrlPkg::JALR;
                    end else begin
                        fmt             = J;
                        ctrl.aluControl = pipeCtrlPkg::JAL;
                    end
                end
                SYSTEM: begin
                    if (funct3 == 3'b000 && instr[31:20] == 12'h000) begin
                        ctrl.ecall      = 1'b1;
                        ctrl.aluControl = ECALL;
                    end
                end
                default: ;  // unknown opcode decodes as a bubble
            endcase
        end
    end

endmodule

/* source/pipeCtrlPkg.sv */
`include "rv_consts.svh"

package pipeCtrlPkg;

    typedef logic [`XLEN-1:0] xlenDataT;

    // operation codes handed to the execute stage
    typedef enum logic [`ALU_OP_W-1:0] {
        NOP    = 6'd0,
        SLL    = 6'd1,
        SRL    = 6'd2,
        SRA    = 6'd3,
        ADD    = 6'd4,  // also load/store address
        SUB    = 6'd5,
        DIV    = 6'd6,
        DIVU   = 6'd7,
        REM    = 6'd8,
        REMU   = 6'd9,
        MUL    = 6'd10,
        MULH   = 6'd11,
        MULHU  = 6'd12,
        MULHSU = 6'd13,
        XOR_OP = 6'd14,
        OR_OP  = 6'd15,
        AND_OP = 6'd16,
        SLT    = 6'd17,
        SLTU   = 6'd18,
        AUIPC  = 6'd19,
        LUI    = 6'd20,
        JALR   = 6'd21,
        JAL    = 6'd22,
        BEQ    = 6'd23,
        BNE    = 6'd24,
        BLT    = 6'd25,
        BGE    = 6'd26,
        BLTU   = 6'd27,
        BGEU   = 6'd28,
        ECALL  = 6'd29,
        SLLW   = 6'd33, // word ops from here on
        SRLW   = 6'd34,
        SRAW   = 6'd35,
        ADDW   = 6'd36,
        SUBW   = 6'd37,
        DIVW   = 6'd38,
        DIVUW  = 6'd39,
        REMW   = 6'd40,
        REMUW  = 6'd41,
        MULW   = 6'd42
    } aluOpE;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        MEM = 2'd1,
        PC4 = 2'd2  // link value for jumps
    } resultSrcE;

    // {kind, funct3}, kind 01 = load, 10 = store
    typedef logic [4:0] memSizeT;

endpackage

/* source/regFile.sv */
`timescale 1ns/1ps
`include "rv_consts.svh"

module regFile
    import rvIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     wbEnable,
    input  regAddrT  wrAddr1,
    input  regAddrT  wrAddr2,
    input  logic     wrEn1,
    input  logic     wrEn2,
    input  xlenDataT wrData1,
    input  xlenDataT wrData2,
    regReadIf.server rd1,
    regReadIf.server rd2
);

    xlenDataT regs [1:`NUM_REGS-1];    // x0 has no storage
    logic     wrLive1;
    logic     wrLive2;

    // lane 2 wins a same-rd collision
    assign wrLive2 = wbEnable && wrEn2 && (wrAddr2 != '0);
    assign wrLive1 = wbEnable && wrEn1 && (wrAddr1 != '0) &&
                     !(wrLive2 && (wrAddr2 == wrAddr1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int r = 1; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (wrLive1) regs[wrAddr1] <= wrData1;
            if (wrLive2) regs[wrAddr2] <= wrData2;
        end
    end

    // write-through, same order as the writeback
    function automatic xlenDataT readReg(input regAddrT addr);
        xlenDataT value;
        if (addr == '0) value = '0;
        else if (wrLive2 && wrAddr2 == addr) value = wrData2;
        else if (wrLive1 && wrAddr1 == addr) value = wrData1;
        else value = regs[addr];
        return value;
    endfunction

    always_comb begin
        rd1.data1 = readReg(rd1.addr1);
        rd1.data2 = readReg(rd1.addr2);
        rd2.data1 = readReg(rd2.addr1);
        rd2.data2 = readReg(rd2.addr2);
    end

endmodule

/* source/rvIsaPkg.sv */
`include "rv_consts.svh"

package rvIsaPkg;

    typedef logic [`ILEN-1:0]       instrT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LOAD      = 7'd3,
        OP_IMM    = 7'd19,
        AUIPC     = 7'd23,
        OP_IMM_32 = 7'd27,
        STORE     = 7'd35,
        OP        = 7'd51,
        LUI       = 7'd55,
        OP_32     = 7'd59,
        BRANCH    = 7'd99,
        JALR      = 7'd103,
        JAL       = 7'd111,
        SYSTEM    = 7'd115
    } opcodeE;

    // immediate layouts
    typedef enum logic [2:0] {
        NONE,
        I,
        S,
        B,
        U,
        J
    } immFmtE;

endpackage

/* source/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// RV64 widths, fixed by the ISA
`define XLEN       64   // register and immediate width
`define ILEN       32   // instruction word
`define NUM_REGS   32   // x0..x31
`define REG_ADDR_W 5    // rs1/rs2/rd field
`define ALU_OP_W   6    // decoded operation code

`endif

/* source/stageIfs.sv */
`timescale 1ns/1ps

// decoded control of one lane
interface decodeCtrlIf
    import rvIsaPkg::*, pipeCtrlPkg::*;
();
    logic      regWrite;
    resultSrcE resultSrc;
    memSizeT   memSize;
    aluOpE     aluControl;
    logic      aluSrc;     // 1 selects imm as operand b
    xlenDataT  imm;
    regAddrT   rs1;
    regAddrT   rs2;
    regAddrT   rd;
    logic      jump;
    logic      branch;
    logic      ecall;

    modport dec (
        output regWrite, resultSrc, memSize, aluControl, aluSrc, imm,
        output rs1, rs2, rd, jump, branch, ecall
    );
    modport user (
        input regWrite, resultSrc, memSize, aluControl, aluSrc, imm,
        input rs1, rs2, rd, jump, branch, ecall
    );
endinterface

// two read ports of one lane
interface regReadIf
    import rvIsaPkg::*, pipeCtrlPkg::*;
();
    regAddrT  addr1;
    regAddrT  addr2;
    xlenDataT data1;
    xlenDataT data2;

    modport client (output addr1, addr2, input data1, data2);
    modport server (input addr1, addr2, output data1, data2);
endinterface

/* verification/dualDecodeStageTb.sv */
`timescale 1ns/1ps

module dualDecodeStageTb
    import rvIsaPkg::*, pipeCtrlPkg::*;
();

    // decoded fields of one lane, in the order they are compared
    typedef struct packed {
        logic        regWrite;
        logic [1:0]  resultSrc;
        logic [4:0]  memSize;
        logic [5:0]  aluOp;
        logic        aluSrc;
        logic        jump;
        logic        branch;
        logic        ecall;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] imm;
    } decodeT;

    logic clk;
    logic rstN;
    logic decodeEnable;
    instrT instr1;
    instrT instr2;
    logic regWrite1, regWrite2;
    resultSrcE resultSrc1, resultSrc2;
    memSizeT memSize1, memSize2;
    aluOpE aluControl1, aluControl2;
    logic aluSrc1, aluSrc2;
    xlenDataT imm1, imm2;
    regAddrT rs1Addr1, rs2Addr1, rdAddr1;
    regAddrT rs1Addr2, rs2Addr2, rdAddr2;
    logic jump1, jump2, branch1, branch2, ecall1, ecall2;
    xlenDataT readData1Lane1, readData2Lane1, readData1Lane2, readData2Lane2;
    logic wbEnable;
    regAddrT wbRd1, wbRd2;
    logic wbRegWrite1, wbRegWrite2;
    xlenDataT wbResult1, wbResult2;

    decodeT act1;
    decodeT act2;
    xlenDataT shadow [32];                  // expected register contents
    logic [31:0] lfsr = 32'h9192_aef2;
    string formName [13] = '{"add", "sub", "mul", "addi", "srai", "lui", "auipc",
                             "ld", "sd", "beq", "jal", "jalr", "ecall"};
    // operation code per form, same order as formName
    logic [5:0] opByForm [13] = '{6'd4, 6'd5, 6'd10, 6'd4, 6'd3, 6'd20, 6'd19,
                                  6'd4, 6'd4, 6'd23, 6'd22, 6'd21, 6'd29};

    assign act1 = {regWrite1, resultSrc1, memSize1, aluControl1, aluSrc1, jump1, branch1,
                   ecall1, rs1Addr1, rs2Addr1, rdAddr1, imm1};
    assign act2 = {regWrite2, resultSrc2, memSize2, aluControl2, aluSrc2, jump2, branch2,
                   ecall2, rs1Addr2, rs2Addr2, rdAddr2, imm2};

    dualDecodeStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] randBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[62:0], lfsr[0]};         // one step per bit
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #2;
        if (i_dut.i_props.failCount != 0) begin
            $display("ERROR a property of the bound checker failed at the last clock edge");
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic setWriteback(input logic en, input regAddrT a1, input logic w1,
                                input xlenDataT d1, input regAddrT a2, input logic w2,
                                input xlenDataT d2);
        wbEnable    = en;
        wbRd1       = a1;
        wbRegWrite1 = w1;
        wbResult1   = d1;
        wbRd2       = a2;
        wbRegWrite2 = w2;
        wbResult2   = d2;
        if (en && w1 && a1 != '0) shadow[a1] = d1;
        if (en && w2 && a2 != '0) shadow[a2] = d2;  // applied last, lane 2 wins
    endtask

    // add instructions just to place read addresses in the rs fields
    task automatic readAndCheck(input string name, input regAddrT a, input regAddrT b,
                                input regAddrT c, input regAddrT d);
        instr1 = {7'h00, b, a, 3'b000, 5'd0, 7'd51};
        instr2 = {7'h00, d, c, 3'b000, 5'd0, 7'd51};
        #10;
        checkValue({name, " lane 1 port 1"}, 128'(shadow[a]), 128'(readData1Lane1));
        checkValue({name, " lane 1 port 2"}, 128'(shadow[b]), 128'(readData2Lane1));
        checkValue({name, " lane 2 port 1"}, 128'(shadow[c]), 128'(readData1Lane2));
        checkValue({name, " lane 2 port 2"}, 128'(shadow[d]), 128'(readData2Lane2));
    endtask

    task automatic makeInstr(input int form, output instrT ins, output decodeT exp);
        regAddrT     rs1;
        regAddrT     rs2;
        regAddrT     rd;
        logic [11:0] i12;
        logic [19:0] u20;
        logic [12:0] b13;
        logic [20:0] j21;
        rs1 = regAddrT'(randBits(5));
        rs2 = regAddrT'(randBits(5));
        rd  = regAddrT'(randBits(5));
        i12 = 12'(randBits(12));
        u20 = 20'(randBits(20));
        b13 = {12'(randBits(12)), 1'b0};    // offsets are even
        j21 = {20'(randBits(20)), 1'b0};
        if (form == 4) i12[11:6] = 6'b010000;   // srai funct6, shamt stays random
        case (form)
            0: ins = {7'h00, rs2, rs1, 3'b000, rd, 7'd51};
            1: ins = {7'h20, rs2, rs1, 3'b000, rd, 7'd51};
            2: ins = {7'h01, rs2, rs1, 3'b000, rd, 7'd51};
            3: ins = {i12, rs1, 3'b000, rd, 7'd19};
            4: ins = {i12, rs1, 3'b101, rd, 7'd19};
            5: ins = {u20, rd, 7'd55};
            6: ins = {u20, rd, 7'd23};
            7: ins = {i12, rs1, 3'b011, rd, 7'd3};
            8: ins = {i12[11:5], rs2, rs1, 3'b011, i12[4:0], 7'd35};
            9: ins = {b13[12], b13[10:5], rs2, rs1, 3'b000, b13[4:1], b13[11], 7'd99};
            10: ins = {j21[20], j21[10:1], j21[11], j21[19:12], rd, 7'd111};
            11: ins = {i12, rs1, 3'b000, rd, 7'd103};
            default: ins = 32'h0000_0073;
        endcase
        exp = '0;
        exp.aluOp = opByForm[form];
        if (form inside {[0:7], 10, 11}) begin
            exp.regWrite = 1'b1;
            exp.rd       = rd;
        end
        if (form inside {[3:8], 10, 11}) exp.aluSrc = 1'b1;    // imm is operand b
        if (form inside {[0:4], 7, 8, 9, 11}) exp.rs1 = rs1;
        if (form inside {[0:2], 8, 9}) exp.rs2 = rs2;
        if (form inside {3, 4, 7, 8, 11}) exp.imm = xlenDataT'($signed(i12));
        if (form inside {5, 6}) exp.imm = xlenDataT'($signed({u20, 12'h000}));
        if (form == 7) begin
            exp.resultSrc = 2'd1;
            exp.memSize   = 5'b01011;       // load, doubleword
        end
        if (form == 8) begin
            exp.memSize = 5'b10011;
            exp.rd      = i12[4:0];         // store keeps the raw rd field
        end
        if (form == 9) begin
            exp.branch = 1'b1;
            exp.imm    = xlenDataT'($signed(b13));
        end
        if (form == 10 || form == 11) begin
            exp.jump      = 1'b1;
            exp.resultSrc = 2'd2;           // link value
        end
        if (form == 10) exp.imm = xlenDataT'($signed(j21));
        if (form == 12) exp.ecall = 1'b1;
    endtask

    initial begin
        regAddrT  a1;
        regAddrT  a2;
        xlenDataT d1;
        xlenDataT d2;
        instrT    ins1;
        instrT    ins2;
        decodeT   exp1;
        decodeT   exp2;
        foreach (shadow[r]) shadow[r] = '0;
        rstN         = 1'b1;
        decodeEnable = 1'b0;
        instr1       = '0;
        instr2       = '0;
        setWriteback(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
        #2 rstN = 1'b0;
        // random read addresses while in reset
        for (int c = 0; c < 3; c++) begin
            stepCycle();
            instr1 = instrT'(randBits(32));
            instr2 = instrT'(randBits(32));
        end
        rstN = 1'b1;
        decodeEnable = 1'b1;

        for (int r = 0; r < 32; r += 4) begin
            stepCycle();
            readAndCheck("reset value", regAddrT'(r), regAddrT'(r + 1),
                         regAddrT'(r + 2), regAddrT'(r + 3));
        end

        // random writes, reads include the rd being written
        repeat (60) begin
            stepCycle();
            a1 = regAddrT'(randBits(5));
            a2 = regAddrT'(randBits(5));
            d1 = randBits(64);
            d2 = randBits(64);
            setWriteback(randBits(2) != 0, a1, randBits(1) != 0, d1,
                         a2, randBits(1) != 0, d2);
            readAndCheck("random write", a1, a2, regAddrT'(randBits(5)),
                         regAddrT'(randBits(5)));
        end
        for (int r = 0; r < 32; r += 4) begin
            stepCycle();
            setWriteback(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
            readAndCheck("readback", regAddrT'(r), regAddrT'(r + 1),
                         regAddrT'(r + 2), regAddrT'(r + 3));
        end

        repeat (4) begin
            stepCycle();
            setWriteback(1'b1, '0, 1'b1, randBits(64), '0, 1'b1, randBits(64));
            readAndCheck("x0 write", '0, '0, '0, '0);
            stepCycle();
            setWriteback(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
            readAndCheck("x0 after write", '0, '0, '0, '0);
        end

        // both lanes on one rd
        repeat (4) begin
            stepCycle();
            a1 = regAddrT'(randBits(5));
            if (a1 == '0) a1 = 5'd1;
            setWriteback(1'b1, a1, 1'b1, randBits(64), a1, 1'b1, randBits(64));
            readAndCheck("same rd bypass", a1, a1, a1, a1);
            stepCycle();
            setWriteback(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
            readAndCheck("same rd stored", a1, a1, a1, a1);
        end

        for (int f = 0; f < 13; f++) begin
            repeat (6) begin
                stepCycle();
                makeInstr(f, ins1, exp1);
                makeInstr(f, ins2, exp2);
                instr1 = ins1;
                instr2 = ins2;
                #10;
                checkValue({formName[f], " lane 1"}, 128'(exp1), 128'(act1));
                checkValue({formName[f], " lane 2"}, 128'(exp2), 128'(act2));
            end
        end

        stepCycle();
        decodeEnable = 1'b0;
        for (int f = 0; f < 13; f++) begin
            stepCycle();
            makeInstr(f, ins1, exp1);
            instr1 = ins1;
            instr2 = instrT'(randBits(32));
            #10;
            checkValue("decode disabled lane 1", '0, 128'(act1));
            checkValue("decode disabled lane 2", '0, 128'(act2));
        end

        stepCycle();
        $display("All tests passed");
        $finish;
    end

endmodule

/* verification/dualDecodeStage_props.sv */
`timescale 1ns/1ps

module dualDecodeStageProps
    import rvIsaPkg::*, pipeCtrlPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     decodeEnable,
    input instrT    instr1,
    input instrT    instr2,
    input logic     regWrite1, regWrite2,
    input logic     aluSrc1, aluSrc2,
    input logic     jump1, jump2,
    input logic     branch1, branch2,
    input logic     ecall1, ecall2,
    input xlenDataT readData1Lane1, readData2Lane1,
    input xlenDataT readData1Lane2, readData2Lane2,
    input logic     wbEnable,
    input regAddrT  wbRd1, wbRd2,
    input logic     wbRegWrite1, wbRegWrite2
);

    logic x0Zero;       // every port addressing x0 reads zero
    logic flagsIdle;
    logic x0Write;
    logic readsZero;
    int   failCount = 0;    // failed assertions so far

    assign x0Zero = (instr1[19:15] != '0 || readData1Lane1 == '0) &&
                    (instr1[24:20] != '0 || readData2Lane1 == '0) &&
                    (instr2[19:15] != '0 || readData1Lane2 == '0) &&
                    (instr2[24:20] != '0 || readData2Lane2 == '0);
    assign flagsIdle = !(regWrite1 || aluSrc1 || jump1 || branch1 || ecall1 ||
                         regWrite2 || aluSrc2 || jump2 || branch2 || ecall2);
    assign x0Write = wbEnable && ((wbRegWrite1 && wbRd1 == '0) ||
                                  (wbRegWrite2 && wbRd2 == '0));
    assign readsZero = readData1Lane1 == '0 && readData2Lane1 == '0 &&
                       readData1Lane2 == '0 && readData2Lane2 == '0;

    x0ReadsZero: assert property (@(posedge clk) !x0Write |-> x0Zero)
        else begin
            $error("read of x0 returned nonzero data");
            failCount++;
        end

    idleWhenDisabled: assert property (@(posedge clk) !decodeEnable |-> flagsIdle)
        else begin
            $error("decoded flag active while decode is disabled");
            failCount++;
        end

    // the bypass must not forward it
    x0WriteIgnored: assert property (@(posedge clk) disable iff (!rstN)
                                     x0Write |-> x0Zero)
        else begin
            $error("write to x0 changed a read of x0");
            failCount++;
        end

    resetReadsZero: assert property (@(posedge clk) !rstN |-> readsZero)
        else begin
            $error("register read nonzero during reset");
            failCount++;
        end

endmodule

bind dualDecodeStage dualDecodeStageProps i_props (.*);
